/* fetch.f */
+incdir+.
fetch_pkg.sv
icache.sv
miss_tracker.sv
fetch_select.sv
fetch.sv
fetch_assert.sv
fetch_tb.sv

/* fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch (
    input  logic                                        clock,
    input  logic                                        reset,
    // redirect, level for as long as the core holds it
    input  logic                                        squash,
    input  logic                                        arbiter_signal,
    input  fetch_pkg::addr_t                            target,
    input  logic [$clog2(`FETCH_BUFF_DEPTH+1)-1:0]      ibuff_open,
    input  fetch_pkg::mem_tag_t                         mem_transaction_tag,
    input  fetch_pkg::mem_tag_t                         mem_data_tag,
    input  fetch_pkg::mem_block_t                       mem_data,
    output logic                                        mem_en,
    output fetch_pkg::addr_t                            mem_addr,
    output fetch_pkg::inst_packet_t [`FETCH_SLOTS-1:0]  out_insts,
    output logic [2:0]                                  out_num_insts,
    output fetch_pkg::addr_t                            npc
);
    import fetch_pkg::*;

    addr_t                                  fetch_addr;
    addr_t                                  fetch_pc;
    addr_t                                  next_fetch_pc;
    block_addr_t [`FETCH_PREFETCH_BLOCKS-1:0] prefetch_block;
    mem_block_t  [`FETCH_PREFETCH_BLOCKS-1:0] block_data;
    logic        [`FETCH_PREFETCH_BLOCKS-1:0] block_hit;
    logic                                   fill_en;
    block_addr_t                            fill_addr;
    mem_block_t                             fill_data;

    // squash target bypasses the register
    assign fetch_pc = squash ? target : fetch_addr;
    assign npc      = fetch_pc;

    // block of the pc and the ones after it
    always_comb begin
        for (int k = 0; k < `FETCH_PREFETCH_BLOCKS; k++) begin
            prefetch_block[k] = fetch_pc[`FETCH_ADDR_BITS-1:3] + block_addr_t'(k);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_addr <= '0;
        end else begin
            fetch_addr <= next_fetch_pc;
        end
    end

    icache icache_0 (
        .clock      (clock),
        .reset      (reset),
        .read_addr  (prefetch_block),
        .write_en   (fill_en),
        .write_addr (fill_addr),
        .write_data (fill_data),
        .read_data  (block_data),
        .read_hit   (block_hit)
    );

    // keeps running through a squash so replies still fill
    miss_tracker miss_tracker_0 (
        .clock               (clock),
        .reset               (reset),
        .arbiter_signal      (arbiter_signal),
        .prefetch_block      (prefetch_block),
        .block_hit           (block_hit),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .fill_en             (fill_en),
        .fill_addr           (fill_addr),
        .fill_data           (fill_data)
    );

    fetch_select fetch_select_0 (
        .clock         (clock),
        .reset         (reset),
        .squash        (squash),
        .fetch_pc      (fetch_pc),
        .block_data    (block_data),
        .block_hit     (block_hit),
        .ibuff_open    (ibuff_open),
        .out_insts     (out_insts),
        .out_num_insts (out_num_insts),
        .next_fetch_pc (next_fetch_pc)
    );

endmodule

`default_nettype wire

/* fetch_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_assert (
    input logic                                                 clock,
    input logic                                                 reset,
    input logic                                                 squash,
    input logic                                                 arbiter_signal,
    input fetch_pkg::mem_tag_t                                  mem_transaction_tag,
    input fetch_pkg::mem_tag_t                                  mem_data_tag,
    input logic                                                 mem_en,
    input fetch_pkg::addr_t                                     mem_addr,
    input fetch_pkg::inst_packet_t [`FETCH_SLOTS-1:0]           out_insts,
    input logic [2:0]                                           out_num_insts,
    input fetch_pkg::block_addr_t  [`FETCH_PREFETCH_BLOCKS-1:0] prefetch_block,
    input logic                    [`FETCH_PREFETCH_BLOCKS-1:0] block_hit
);
    import fetch_pkg::*;

    // number of failed checks so far
    int error_count = 0;

    // requests still out, seen at the memory ports
    logic [`FETCH_NUM_TAGS:1]          pending_valid;
    block_addr_t                       pending_block [1:`FETCH_NUM_TAGS];
    logic [`FETCH_PREFETCH_BLOCKS-1:0] pending_hit;

    logic        wanted_found;
    block_addr_t wanted_block;

    // a reply frees its tag, a request takes the offered one
    always_ff @(posedge clock) begin
        if (reset) begin
            pending_valid <= '0;
        end else begin
            if (mem_data_tag != '0) begin
                pending_valid[mem_data_tag] <= 1'b0;
            end
            if (mem_en && (mem_transaction_tag != '0)) begin
                pending_valid[mem_transaction_tag] <= 1'b1;
            end
        end
    end

    // requested block per tag
    always_ff @(posedge clock) begin
        if (mem_en && (mem_transaction_tag != '0)) begin
            pending_block[mem_transaction_tag] <= mem_addr[`FETCH_ADDR_BITS-1:3];
        end
    end

    // prefetch blocks already on their way
    always_comb begin
        pending_hit = '0;
        for (int b = 0; b < `FETCH_PREFETCH_BLOCKS; b++) begin
            for (int t = 1; t <= `FETCH_NUM_TAGS; t++) begin
                if (pending_valid[t] && (pending_block[t] == prefetch_block[b])) begin
                    pending_hit[b] = 1'b1;
                end
            end
        end
    end

    // lowest prefetch block that misses and is not on its way
    always_comb begin
        wanted_found = 1'b0;
        wanted_block = '0;
        for (int b = 0; b < `FETCH_PREFETCH_BLOCKS; b++) begin
            if (!wanted_found && !block_hit[b] && !pending_hit[b]) begin
                wanted_found = 1'b1;
                wanted_block = prefetch_block[b];
            end
        end
    end

    // port granted and a tag offered
    request_needs_grant: assert property (@(posedge clock) disable iff (reset)
        mem_en |-> arbiter_signal && (mem_transaction_tag != '0))
    else begin
        error_count = error_count + 1;
        $error("mem_en raised without grant or tag");
    end

    request_aligned: assert property (@(posedge clock) disable iff (reset)
        mem_en |-> (mem_addr[2:0] == 3'b000))
    else begin
        error_count = error_count + 1;
        $error("mem_addr not block aligned");
    end

    // first missing block goes out, not a later one
    request_lowest_block: assert property (@(posedge clock) disable iff (reset)
        mem_en |-> (mem_addr[`FETCH_ADDR_BITS-1:3] == wanted_block))
    else begin
        error_count = error_count + 1;
        $error("request is not the lowest missing prefetch block");
    end

    // zero cycles from miss to request
    miss_requests_now: assert property (@(posedge clock) disable iff (reset)
        (arbiter_signal && (mem_transaction_tag != '0) && wanted_found) |-> mem_en)
    else begin
        error_count = error_count + 1;
        $error("missing block not requested in the same cycle");
    end

    count_limit: assert property (@(posedge clock) disable iff (reset)
        out_num_insts <= 3'(`FETCH_SLOTS))
    else begin
        error_count = error_count + 1;
        $error("more instructions than slots");
    end

    squash_clears: assert property (@(posedge clock) disable iff (reset)
        squash |=> (out_num_insts == '0))
    else begin
        error_count = error_count + 1;
        $error("packets shown right after squash");
    end

    reset_clears: assert property (@(posedge clock)
        reset |=> (out_num_insts == '0) && (out_insts == '0))
    else begin
        error_count = error_count + 1;
        $error("outputs not cleared by reset");
    end

    // slot shape, low slots valid and the rest zero
    for (genvar i = 0; i < `FETCH_SLOTS; i++) begin : g_slot
        slot_shape: assert property (@(posedge clock) disable iff (reset)
            (3'(i) < out_num_insts) |->
                out_insts[i].valid
                && (out_insts[i].npc == out_insts[i].pc + 32'd4)
                && (out_insts[i].pc == out_insts[0].pc + 32'(4 * i)))
        else begin
            error_count = error_count + 1;
            $error("valid slot %0d has a bad pc chain", i);
        end

        slot_empty: assert property (@(posedge clock) disable iff (reset)
            !(3'(i) < out_num_insts) |-> (out_insts[i] == '0))
        else begin
            error_count = error_count + 1;
            $error("unused slot %0d not zero", i);
        end
    end

endmodule

bind fetch fetch_assert fetch_checks (
    .clock               (clock),
    .reset               (reset),
    .squash              (squash),
    .arbiter_signal      (arbiter_signal),
    .mem_transaction_tag (mem_transaction_tag),
    .mem_data_tag        (mem_data_tag),
    .mem_en              (mem_en),
    .mem_addr            (mem_addr),
    .out_insts           (out_insts),
    .out_num_insts       (out_num_insts),
    .prefetch_block      (prefetch_block),
    .block_hit           (block_hit)
);

`default_nettype wire

/* fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// usable memory tags, tag 0 means no transaction
`define FETCH_NUM_TAGS 15

// blocks looked up ahead of the fetch pc
`define FETCH_PREFETCH_BLOCKS 3

// direct-mapped icache lines
`define FETCH_CACHE_LINES 32

// instruction slots presented per cycle
`define FETCH_SLOTS 4

// instruction buffer entries
// ibuff_open counts 0 to this value inclusive
`define FETCH_BUFF_DEPTH 16

// byte address width
`define FETCH_ADDR_BITS 32

`endif

/* fetch_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // byte address
    typedef logic [`FETCH_ADDR_BITS-1:0] addr_t;

    // memory tag, zero reserved for "none"
    typedef logic [$clog2(`FETCH_NUM_TAGS+1)-1:0] mem_tag_t;

    // one 64-bit block as two instruction words
    // word 0 sits at the lower address, in bits 31:0
    typedef logic [1:0][31:0] mem_block_t;

    // address with the 3 byte-offset bits dropped
    typedef logic [`FETCH_ADDR_BITS-4:0] block_addr_t;

    // one fetched instruction, 97 bits
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        addr_t       pc;
        addr_t       npc;
    } inst_packet_t;

endpackage

`default_nettype wire

/* fetch_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_select (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  logic                                                 squash,
    input  fetch_pkg::addr_t                                     fetch_pc,
    input  fetch_pkg::mem_block_t  [`FETCH_PREFETCH_BLOCKS-1:0] block_data,
    input  logic                   [`FETCH_PREFETCH_BLOCKS-1:0] block_hit,
    // free instruction buffer entries
    input  logic [$clog2(`FETCH_BUFF_DEPTH+1)-1:0]               ibuff_open,
    output fetch_pkg::inst_packet_t [`FETCH_SLOTS-1:0]           out_insts,
    output logic [2:0]                                           out_num_insts,
    output fetch_pkg::addr_t                                     next_fetch_pc
);
    import fetch_pkg::*;

    localparam int OPEN_BITS = $clog2(`FETCH_BUFF_DEPTH + 1);

    // word position of each slot counted from word 0 of block 0
    logic [2:0]                        slot_word [`FETCH_SLOTS];
    logic [2:0]                        avail_count;
    logic                              run;
    logic [OPEN_BITS-1:0]              room;
    logic [2:0]                        take_count;
    inst_packet_t [`FETCH_SLOTS-1:0]   next_insts;

    // start at word 1 when pc sits in the upper half
    always_comb begin
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            slot_word[i] = {2'b00, fetch_pc[2]} + 3'(i);
        end
    end

    // consecutive words through hit blocks
    // four slots cap the count at four
    always_comb begin
        avail_count = '0;
        run         = 1'b1;
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            if (run && block_hit[slot_word[i][2:1]]) begin
                avail_count = avail_count + 3'd1;
            end else begin
                run = 1'b0;
            end
        end
    end

    // buffer space left after what is shown now
    always_comb begin
        if (ibuff_open > OPEN_BITS'(out_num_insts)) begin
            room = ibuff_open - OPEN_BITS'(out_num_insts);
        end else begin
            room = '0;
        end
    end

    // nothing taken on squash, so the pc stays at target
    always_comb begin
        if (squash) begin
            take_count = '0;
        end else if (OPEN_BITS'(avail_count) < room) begin
            take_count = avail_count;
        end else begin
            take_count = room[2:0];
        end
    end

    // packets, unused slots stay zero
    always_comb begin
        next_insts = '0;
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            if (3'(i) < take_count) begin
                next_insts[i].valid = 1'b1;
                next_insts[i].inst  = block_data[slot_word[i][2:1]][slot_word[i][0]];
                next_insts[i].pc    = fetch_pc + addr_t'(4 * i);
                next_insts[i].npc   = fetch_pc + addr_t'(4 * i + 4);
            end
        end
    end

    // 4 bytes per presented instruction
    assign next_fetch_pc = fetch_pc + addr_t'({take_count, 2'b00});

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            out_insts     <= '0;
            out_num_insts <= '0;
        end else begin
            out_insts     <= next_insts;
            out_num_insts <= take_count;
        end
    end

endmodule

`default_nettype wire

/* fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int NUM_CYCLES  = 4000;
    localparam int MAX_DELAY   = 8;
    localparam int CLOCK_NS    = 4;
    localparam int WATCHDOG_NS = (NUM_CYCLES + 20) * MAX_DELAY * CLOCK_NS;
    localparam logic [31:0] WORD_KEY = 32'h5a5a0000;

    logic                                   clock;
    logic                                   reset;
    logic                                   squash;
    logic                                   arbiter_signal;
    addr_t                                  target;
    logic [$clog2(`FETCH_BUFF_DEPTH+1)-1:0] ibuff_open;
    mem_tag_t                               mem_transaction_tag;
    mem_tag_t                               mem_data_tag;
    mem_block_t                             mem_data;
    logic                                   mem_en;
    addr_t                                  mem_addr;
    inst_packet_t [`FETCH_SLOTS-1:0]        out_insts;
    logic [2:0]                             out_num_insts;
    addr_t                                  npc;

    // memory model, one entry per tag
    logic [`FETCH_NUM_TAGS:1] tag_busy;
    block_addr_t              tag_block [1:`FETCH_NUM_TAGS];
    int                       tag_due [1:`FETCH_NUM_TAGS];

    logic [31:0] lfsr_state;
    int          cycle;
    addr_t       expect_pc;
    logic        replied;
    logic        prev_squash;
    addr_t       prev_target;
    int          prev_num;
    int          prev_open;

    fetch dut (
        .clock               (clock),
        .reset               (reset),
        .squash              (squash),
        .arbiter_signal      (arbiter_signal),
        .target              (target),
        .ibuff_open          (ibuff_open),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .out_insts           (out_insts),
        .out_num_insts       (out_num_insts),
        .npc                 (npc)
    );

    always #(CLOCK_NS / 2) clock = ~clock;

    // galois lfsr, one step per bit
    function automatic logic next_random_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    // memory contents
    function automatic logic [31:0] word_at(input addr_t a);
        return a ^ WORD_KEY;
    endfunction

    function automatic mem_block_t block_at(input block_addr_t b);
        addr_t a;
        a = {b, 3'b000};
        return {word_at(a + 32'd4), word_at(a)};
    endfunction

    task automatic fail_with(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else report_mismatch(name, expected, actual);
    endtask

    task automatic check_bound_assertions();
        assert (dut.fetch_checks.error_count == 0)
        else fail_with("a bound assertion on the fetch stage failed");
    endtask

    // replies, tag offer and random control, 1 ns after the edge
    task automatic drive_inputs();
        int reply;
        int offer;
        reply = 0;
        offer = 0;
        for (int t = 1; t <= `FETCH_NUM_TAGS; t++) begin
            if (reply == 0 && tag_busy[t] && tag_due[t] <= cycle) begin
                reply = t;
            end
        end
        // replying tag stays busy for this cycle
        for (int t = 1; t <= `FETCH_NUM_TAGS; t++) begin
            if (offer == 0 && !tag_busy[t]) begin
                offer = t;
            end
        end
        mem_data_tag        = mem_tag_t'(reply);
        mem_data            = (reply != 0) ? block_at(tag_block[reply]) : '0;
        mem_transaction_tag = mem_tag_t'(offer);
        arbiter_signal      = (random_bits(3) != 0);
        ibuff_open          = 5'(random_bits(4) % 9);
        squash              = (random_bits(5) == 0);
        // small region so blocks come back and lines get evicted
        target              = addr_t'(random_bits(7)) << 2;
    endtask

    task automatic check_outputs();
        int n;
        n = int'(out_num_insts);
        assert (n <= `FETCH_SLOTS) else report_mismatch("slot_limit", `FETCH_SLOTS, n);
        if (n != 0 && n + prev_num > prev_open) begin
            report_mismatch("buffer_limit", prev_open - prev_num, n);
        end
        if (!replied) begin
            check_equal("idle_before_fill", 0, n);
        end
        if (prev_squash) begin
            check_equal("squash_clear", 0, n);
            expect_pc = prev_target;
        end else begin
            // chain through the slots from the last next pc
            for (int i = 0; i < n; i++) begin
                check_equal("slot_valid", 1, out_insts[i].valid);
                check_equal("slot_pc", expect_pc, out_insts[i].pc);
                check_equal("slot_inst", word_at(expect_pc), out_insts[i].inst);
                check_equal("slot_npc", expect_pc + 32'd4, out_insts[i].npc);
                expect_pc = out_insts[i].npc;
            end
        end
        // fetch pc follows the last shown next pc, target while squashing
        check_equal("npc", squash ? target : expect_pc, npc);
        prev_squash = squash;
        prev_target = target;
        prev_num    = n;
        prev_open   = int'(ibuff_open);
    endtask

    // request and reply bookkeeping
    task automatic track_memory();
        if (mem_en) begin
            check_equal("mem_addr_align", 0, mem_addr[2:0]);
            for (int t = 1; t <= `FETCH_NUM_TAGS; t++) begin
                if (tag_busy[t] && tag_block[t] == mem_addr[`FETCH_ADDR_BITS-1:3]) begin
                    fail_with("mem_addr requests a block that is still outstanding");
                end
            end
            assert (mem_transaction_tag != '0)
            else fail_with("request made without an offered tag");
            tag_busy[mem_transaction_tag]  = 1'b1;
            tag_block[mem_transaction_tag] = mem_addr[`FETCH_ADDR_BITS-1:3];
            tag_due[mem_transaction_tag]   = cycle + 1 + int'(random_bits(3));
        end
        if (mem_data_tag != '0) begin
            replied                = 1'b1;
            tag_busy[mem_data_tag] = 1'b0;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_with("watchdog expired before the stimulus finished");
    end

    initial begin
        clock               = 1'b0;
        reset               = 1'b1;
        squash              = 1'b0;
        arbiter_signal      = 1'b0;
        target              = '0;
        ibuff_open          = '0;
        mem_transaction_tag = '0;
        mem_data_tag        = '0;
        mem_data            = '0;
        lfsr_state          = 32'h92c0;
        tag_busy            = '0;
        expect_pc           = '0;
        replied             = 1'b0;
        prev_squash         = 1'b0;
        prev_target         = '0;
        prev_num            = 0;
        prev_open           = 0;
        cycle               = 0;

        // two reset edges
        @(posedge clock);
        @(negedge clock);
        check_equal("reset_mem_en", 0, mem_en);
        check_equal("reset_num_insts", 0, out_num_insts);
        @(posedge clock);
        #1;
        reset = 1'b0;

        for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            drive_inputs();
            @(negedge clock);
            check_bound_assertions();
            check_outputs();
            track_memory();
            @(posedge clock);
            #1;
        end

        @(negedge clock);
        if (dut.fetch_checks.error_count != 0) begin
            fail_with("a bound assertion failed at the end of the run");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module icache (
    input  logic                                                 clock,
    input  logic                                                 reset,
    // one lookup per prefetch block
    input  fetch_pkg::block_addr_t [`FETCH_PREFETCH_BLOCKS-1:0] read_addr,
    // fill from the miss table
    input  logic                                                 write_en,
    input  fetch_pkg::block_addr_t                               write_addr,
    input  fetch_pkg::mem_block_t                                write_data,
    output fetch_pkg::mem_block_t  [`FETCH_PREFETCH_BLOCKS-1:0] read_data,
    output logic                   [`FETCH_PREFETCH_BLOCKS-1:0] read_hit
);
    import fetch_pkg::*;

    localparam int INDEX_BITS = $clog2(`FETCH_CACHE_LINES);
    localparam int TAG_BITS   = $bits(block_addr_t) - INDEX_BITS;

    // line storage
    mem_block_t                    line_data [`FETCH_CACHE_LINES];
    logic [TAG_BITS-1:0]           line_tag  [`FETCH_CACHE_LINES];
    logic [`FETCH_CACHE_LINES-1:0] line_valid;

    // split the fill address
    logic [INDEX_BITS-1:0] write_index;
    logic [TAG_BITS-1:0]   write_tag;

    assign write_index = write_addr[INDEX_BITS-1:0];
    assign write_tag   = write_addr[$bits(block_addr_t)-1:INDEX_BITS];

    // combinational read ports
    for (genvar p = 0; p < `FETCH_PREFETCH_BLOCKS; p++) begin : g_port
        logic [INDEX_BITS-1:0] index;
        logic [TAG_BITS-1:0]   tag;

        assign index = read_addr[p][INDEX_BITS-1:0];
        assign tag   = read_addr[p][$bits(block_addr_t)-1:INDEX_BITS];

        assign read_data[p] = line_data[index];
        // hit needs a filled line with a matching tag
        assign read_hit[p]  = line_valid[index] && (line_tag[index] == tag);
    end

    // fill replaces the whole line
    always_ff @(posedge clock) begin
        if (write_en) begin
            line_data[write_index] <= write_data;
            line_tag[write_index]  <= write_tag;
        end
    end

    // valid bits, cleared only by reset
    // squash leaves lines alone since memory is read-only
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (write_en) begin
            line_valid[write_index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* miss_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module miss_tracker (
    input  logic                                                 clock,
    input  logic                                                 reset,
    // high when fetch owns the memory port
    input  logic                                                 arbiter_signal,
    input  fetch_pkg::block_addr_t [`FETCH_PREFETCH_BLOCKS-1:0] prefetch_block,
    input  logic                   [`FETCH_PREFETCH_BLOCKS-1:0] block_hit,
    // tag offered for a new request, 0 when memory is busy
    input  fetch_pkg::mem_tag_t                                  mem_transaction_tag,
    // tag of the reply on mem_data, 0 when idle
    input  fetch_pkg::mem_tag_t                                  mem_data_tag,
    input  fetch_pkg::mem_block_t                                mem_data,
    output logic                                                 mem_en,
    output fetch_pkg::addr_t                                     mem_addr,
    output logic                                                 fill_en,
    output fetch_pkg::block_addr_t                               fill_addr,
    output fetch_pkg::mem_block_t                                fill_data
);
    import fetch_pkg::*;

    // one entry per tag, tag 0 has none
    block_addr_t               entry_addr [1:`FETCH_NUM_TAGS];
    logic [`FETCH_NUM_TAGS:1]  entry_valid;

    logic [`FETCH_PREFETCH_BLOCKS-1:0] in_table;
    logic                              req_found;
    block_addr_t                       req_block;
    logic                              can_request;

    // blocks already on their way from memory
    always_comb begin
        in_table = '0;
        for (int b = 0; b < `FETCH_PREFETCH_BLOCKS; b++) begin
            for (int t = 1; t <= `FETCH_NUM_TAGS; t++) begin
                if (entry_valid[t] && (entry_addr[t] == prefetch_block[b])) begin
                    in_table[b] = 1'b1;
                end
            end
        end
    end

    // walk down so the lowest missing block wins
    always_comb begin
        req_found = 1'b0;
        req_block = '0;
        for (int b = `FETCH_PREFETCH_BLOCKS - 1; b >= 0; b--) begin
            if (!block_hit[b] && !in_table[b]) begin
                req_found = 1'b1;
                req_block = prefetch_block[b];
            end
        end
    end

    // memory free and a tag offered
    assign can_request = arbiter_signal && (mem_transaction_tag != '0);

    // at most one request per cycle, block aligned
    assign mem_en   = can_request && req_found;
    assign mem_addr = mem_en ? {req_block, 3'b000} : '0;

    // reply retires only against a live entry
    assign fill_en   = (mem_data_tag != '0) && entry_valid[mem_data_tag];
    assign fill_data = mem_data;

    always_comb begin
        fill_addr = '0;
        if (fill_en) begin
            fill_addr = entry_addr[mem_data_tag];
        end
    end

    // retire first, so a reused tag ends up allocated
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            if (fill_en) begin
                entry_valid[mem_data_tag] <= 1'b0;
            end
            if (mem_en) begin
                entry_valid[mem_transaction_tag] <= 1'b1;
            end
        end
    end

    // recorded block per tag
    always_ff @(posedge clock) begin
        if (mem_en) begin
            entry_addr[mem_transaction_tag] <= req_block;
        end
    end

endmodule

`default_nettype wire
